/* design/mips_pkg.sv */
package mips_pkg;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        op_special = 6'b000000,
        op_regimm  = 6'b000001,
        op_j       = 6'b000010,
        op_beq     = 6'b000100,
        op_bne     = 6'b000101,
        op_addiu   = 6'b001001,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_e;

    // funct field of special instructions, bits 5:0
    typedef enum logic [5:0] {
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_and  = 6'b100100,
        fn_or   = 6'b100101,
        fn_slt  = 6'b101010
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // kinds of control transfer
    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_bltz,
        br_bgez,
        br_j,
        br_jr
    } branch_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        use_imm;
        logic        reg_write;
        logic [4:0]  dest;
        logic        mem_read;
        logic        mem_write;
        branch_e     branch;
        logic [31:0] imm;
        logic [25:0] jump_index;
        logic        illegal;
    } ctrl_t;

    localparam logic [31:0] reset_vector = 32'hBFC00000;
    // jumping here stops the processor once the delay slot retires
    localparam logic [31:0] halt_address = 32'h00000000;
    localparam logic [4:0]  reg_v0       = 5'd2;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  logic [31:0]     instr,
    output mips_pkg::ctrl_t ctrl
);
    import mips_pkg::*;

    opcode_e    opcode;
    funct_e     funct;
    logic [4:0] rt;
    logic [4:0] rd;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        // default is a nop that writes nothing
        ctrl            = '0;
        ctrl.alu_op     = alu_pass_b;
        ctrl.branch     = br_none;
        ctrl.dest       = rt;
        ctrl.imm        = {{16{instr[15]}}, instr[15:0]};
        ctrl.jump_index = instr[25:0];

        case (opcode)
            op_special: begin
                ctrl.dest = rd;
                case (funct)
                    fn_addu: begin
                        ctrl.alu_op    = alu_add;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_subu: begin
                        ctrl.alu_op    = alu_sub;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_and: begin
                        ctrl.alu_op    = alu_and;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_or: begin
                        ctrl.alu_op    = alu_or;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_slt: begin
                        ctrl.alu_op    = alu_slt;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_jr: ctrl.branch = br_jr;
                    // the all-zero word is the usual nop
                    default: ctrl.illegal = (instr != 32'h0);
                endcase
            end
            op_regimm: begin
                // rt selects the condition
                case (rt)
                    5'd0:    ctrl.branch  = br_bltz;
                    5'd1:    ctrl.branch  = br_bgez;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_j:   ctrl.branch = br_j;
            op_beq: ctrl.branch = br_beq;
            op_bne: ctrl.branch = br_bne;
            op_addiu: begin
                ctrl.alu_op    = alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_lw: begin
                ctrl.alu_op    = alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            op_sw: begin
                ctrl.alu_op    = alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_value,
    output logic [31:0] rt_value,
    input  logic        write_enable,
    input  logic [4:0]  write_addr,
    input  logic [31:0] write_data,
    output logic [31:0] v0_value
);
    import mips_pkg::*;

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (write_enable && write_addr != 5'd0) begin
            // r0 is never written so it reads as zero
            regs[write_addr] <= write_data;
        end
    end

    // combinational read ports
    assign rs_value = regs[rs_addr];
    assign rt_value = regs[rt_addr];
    assign v0_value = regs[reg_v0];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mips_pkg::ctrl_t ctrl,
    input  logic [31:0]     rs_value,
    input  logic [31:0]     rt_value,
    output logic [31:0]     result
);
    import mips_pkg::*;

    logic [31:0] operand_b;
    logic [31:0] sum;
    logic [31:0] difference;
    logic        less_than;

    // immediate forms use the sign-extended field
    assign operand_b = ctrl.use_imm ? ctrl.imm : rt_value;

    // also the lw/sw address
    assign sum = rs_value + operand_b;

    assign difference = rs_value - operand_b;

    // signed compare for slt
    assign less_than = $signed(rs_value) < $signed(operand_b);

    always_comb begin
        case (ctrl.alu_op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = difference;
            end
            alu_and: begin
                result = rs_value & operand_b;
            end
            alu_or: begin
                result = rs_value | operand_b;
            end
            alu_slt: begin
                result = {31'h0, less_than};
            end
            default: begin
                result = operand_b;
            end
        endcase
    end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  mips_pkg::ctrl_t ctrl,
    input  logic [31:0]     pc,
    input  logic [31:0]     rs_value,
    input  logic [31:0]     rt_value,
    output logic            taken,
    output logic [31:0]     target
);
    import mips_pkg::*;

    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;

    assign pc_plus4 = pc + 32'd4;

    // word offset relative to the delay slot
    assign branch_target = pc_plus4 + {ctrl.imm[29:0], 2'b00};

    // stays inside the current 256 MB region
    assign jump_target = {pc_plus4[31:28], ctrl.jump_index, 2'b00};

    always_comb begin
        taken  = 1'b0;
        target = pc_plus4;
        case (ctrl.branch)
            br_beq: begin
                taken  = (rs_value == rt_value);
                target = branch_target;
            end
            br_bne: begin
                taken  = (rs_value != rt_value);
                target = branch_target;
            end
            br_bltz: begin
                taken  = rs_value[31];
                target = branch_target;
            end
            br_bgez: begin
                taken  = ~rs_value[31];
                target = branch_target;
            end
            br_j: begin
                taken  = 1'b1;
                target = jump_target;
            end
            br_jr: begin
                taken  = 1'b1;
                target = rs_value;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

/* design/pc_sequencer.sv */
`timescale 1ns/1ps

module pc_sequencer (
    input  logic        clk,
    input  logic        reset,
    input  logic        taken,
    input  logic [31:0] target,
    output logic [31:0] pc,
    output logic        active
);
    import mips_pkg::*;

    // target waiting for the delay slot to retire
    logic        pending;
    logic [31:0] pending_target;
    logic        halting;

    assign halting = pending && (pending_target == halt_address);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= reset_vector;
            active  <= 1'b1;
            pending <= 1'b0;
        end else if (active) begin
            if (halting) begin
                // pc freezes on the delay slot
                active <= 1'b0;
            end else if (pending) begin
                pc <= pending_target;
            end else begin
                pc <= pc + 32'd4;
            end
            pending <= taken;
        end
    end

    // payload only, qualified by pending
    always_ff @(posedge clk) begin
        if (active && taken) begin
            pending_target <= target;
        end
    end

endmodule

/* design/mips_cpu.sv */
`timescale 1ns/1ps

module mips_cpu (
    input  logic        clk,
    input  logic        reset,
    output logic        active,
    output logic [31:0] register_v0,

    // instruction port, combinational read
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // data port, combinational read and clocked write
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);
    import mips_pkg::*;

    ctrl_t       ctrl;
    logic [31:0] pc;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] result;
    logic [31:0] target;
    logic [31:0] write_back;
    logic        taken;
    logic        running;

    // strobes are only live while the sequencer runs
    assign running = active & ~reset;

    assign instr_address = pc;

    instr_decoder u_instr_decoder (
        .instr (instr_readdata),
        .ctrl  (ctrl)
    );

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .rs_addr      (instr_readdata[25:21]),
        .rt_addr      (instr_readdata[20:16]),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .write_enable (ctrl.reg_write & running),
        .write_addr   (ctrl.dest),
        .write_data   (write_back),
        .v0_value     (register_v0)
    );

    alu u_alu (
        .ctrl     (ctrl),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .result   (result)
    );

    branch_unit u_branch_unit (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .taken    (taken),
        .target   (target)
    );

    pc_sequencer u_pc_sequencer (
        .clk    (clk),
        .reset  (reset),
        .taken  (taken),
        .target (target),
        .pc     (pc),
        .active (active)
    );

    assign data_address   = result;
    assign data_writedata = rt_value;
    assign data_write     = ctrl.mem_write & running;
    assign data_read      = ctrl.mem_read & running;

    // loads write back the memory word
    assign write_back = ctrl.mem_read ? data_readdata : result;

endmodule

/* test/test_memory.sv */
`timescale 1ns/1ps

module test_memory (
    input  logic        clk,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic        data_read,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);
    // 1 KB windows for code and data
    localparam logic [31:0] instr_base = 32'hBFC00000;
    localparam logic [31:0] data_base  = 32'h00001000;

    logic [31:0] instr_mem [0:255];
    logic [31:0] data_mem [0:255];
    logic        instr_hit;
    logic        data_hit;

    assign instr_hit = (instr_address[31:10] == instr_base[31:10]);
    assign data_hit  = (data_address[31:10] == data_base[31:10]);

    // unmapped code reads as nop
    assign instr_readdata = instr_hit ? instr_mem[instr_address[9:2]] : 32'h0;

    always_comb begin
        if (!data_read) begin
            data_readdata = 32'h0;
        end else if (data_hit) begin
            data_readdata = data_mem[data_address[9:2]];
        end else begin
            // unmapped data reads return the inverted address
            data_readdata = ~data_address;
        end
    end

    always @(posedge clk) begin
        if (data_write && data_hit) begin
            data_mem[data_address[9:2]] <= data_writedata;
        end
    end

endmodule

/* test/mips_cpu_tb.sv */
`timescale 1ns/1ps

module mips_cpu_tb;
    import mips_pkg::*;

    localparam logic [31:0] data_base = 32'h00001000;

    // architectural state of the reference model
    typedef struct packed {
        logic [31:0]       pc;
        logic              pending;
        logic [31:0]       pending_target;
        logic              active;
        logic [31:0][31:0] regs;
    } model_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    model_t      model;
    logic [31:0] prog_words [0:255];
    logic [31:0] model_data [0:255];
    logic [7:0]  next_index;
    int          prog_len;
    int          error_count;
    int          timeouts;
    logic        checking;
    integer      seed;

    mips_cpu u_mips_cpu (.*);

    test_memory u_test_memory (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rtype(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_to(logic [7:0] index);
        logic [31:0] target;
        target = reset_vector + {22'h0, index, 2'b00};
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] addr);
        if (addr[31:10] == reset_vector[31:10]) begin
            return prog_words[addr[9:2]];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] load_word(logic [31:0] addr);
        if (addr[31:10] == data_base[31:10]) begin
            return model_data[addr[9:2]];
        end
        return ~addr;
    endfunction

    // one instruction of the ISA, including the delay slot and the halt
    function automatic model_t model_step(model_t s, logic [31:0] instr);
        model_t      n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc4;
        logic [31:0] value;
        logic [31:0] target;
        logic [4:0]  dest;
        logic        taken;
        n      = s;
        a      = s.regs[instr[25:21]];
        b      = s.regs[instr[20:16]];
        imm    = {{16{instr[15]}}, instr[15:0]};
        pc4    = s.pc + 32'd4;
        value  = 32'h0;
        dest   = 5'd0;
        taken  = 1'b0;
        target = pc4 + (imm << 2);
        case (instr[31:26])
            6'h00: begin
                dest = instr[15:11];
                case (instr[5:0])
                    6'h21: value = a + b;
                    6'h23: value = a - b;
                    6'h24: value = a & b;
                    6'h25: value = a | b;
                    6'h2a: value = {31'h0, $signed(a) < $signed(b)};
                    6'h08: begin
                        dest   = 5'd0;
                        taken  = 1'b1;
                        target = a;
                    end
                    default: dest = 5'd0;
                endcase
            end
            6'h01: taken = (instr[20:16] == 5'd0) ? a[31] : ~a[31];
            6'h02: begin
                taken  = 1'b1;
                target = {pc4[31:28], instr[25:0], 2'b00};
            end
            6'h04: taken = (a == b);
            6'h05: taken = (a != b);
            6'h09: begin
                dest  = instr[20:16];
                value = a + imm;
            end
            6'h23: begin
                dest  = instr[20:16];
                value = load_word(a + imm);
            end
            default: dest = 5'd0;
        endcase
        if (dest != 5'd0) begin
            n.regs[dest] = value;
        end
        if (s.pending && s.pending_target == halt_address) begin
            n.active = 1'b0;
        end else if (s.pending) begin
            n.pc = s.pending_target;
        end else begin
            n.pc = pc4;
        end
        n.pending = taken;
        if (taken) begin
            n.pending_target = target;
        end
        return n;
    endfunction

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic emit(logic [31:0] word);
        prog_words[next_index]              = word;
        u_test_memory.instr_mem[next_index] = word;
        next_index = next_index + 8'd1;
        prog_len++;
    endtask

    task automatic set_origin(logic [7:0] index);
        next_index = index;
    endtask

    task automatic preset_data(logic [7:0] index, logic [31:0] word);
        model_data[index]              = word;
        u_test_memory.data_mem[index] <= word;
    endtask

    task automatic clear_memories();
        logic [31:0] fill;
        for (int i = 0; i < 256; i++) begin
            fill = (data_base + 32'(i * 4)) ^ 32'h5ac3_3ca5;
            prog_words[8'(i)]              = 32'h0;
            u_test_memory.instr_mem[8'(i)] = 32'h0;
            preset_data(8'(i), fill);
        end
        next_index = 8'd0;
        prog_len   = 0;
    endtask

    // lw of a jump target, jr through it, then halt
    task automatic boot_program();
        preset_data(8'd0, 32'hBFC00100);
        emit(itype(6'h23, 5'd0, 5'd1, 16'h1000));
        emit(rtype(5'd1, 5'd0, 5'd0, 6'h08));
        emit(itype(6'h09, 5'd0, 5'd2, 16'h0005));
        set_origin(8'd64);
        emit(rtype(5'd2, 5'd1, 5'd2, 6'h21));
        emit(rtype(5'd0, 5'd0, 5'd0, 6'h08));
        emit(32'h0);
    endtask

    task automatic branch_program();
        emit(itype(6'h09, 5'd0, 5'd3, 16'hfffe));
        emit(itype(6'h09, 5'd0, 5'd4, 16'h0003));
        emit(itype(6'h04, 5'd3, 5'd4, 16'h0002));
        emit(itype(6'h09, 5'd0, 5'd2, 16'h0001));
        // bne taken to 7, slot at 5
        emit(itype(6'h05, 5'd3, 5'd4, 16'h0002));
        emit(itype(6'h09, 5'd2, 5'd2, 16'h0001));
        set_origin(8'd7);
        emit(itype(6'h01, 5'd3, 5'd0, 16'h0002));
        emit(itype(6'h09, 5'd2, 5'd2, 16'h0002));
        set_origin(8'd10);
        emit(itype(6'h01, 5'd3, 5'd1, 16'h0003));
        emit(itype(6'h09, 5'd2, 5'd2, 16'h0008));
        emit(itype(6'h01, 5'd4, 5'd0, 16'h0003));
        emit(itype(6'h09, 5'd0, 5'd5, 16'h0002));
        // countdown loop closed by a backward bgez
        emit(itype(6'h09, 5'd5, 5'd5, 16'hffff));
        emit(itype(6'h01, 5'd5, 5'd1, 16'hfffe));
        emit(itype(6'h09, 5'd2, 5'd2, 16'h0004));
        emit(itype(6'h05, 5'd4, 5'd4, 16'h0002));
        emit(itype(6'h04, 5'd4, 5'd4, 16'h0002));
        emit(itype(6'h09, 5'd2, 5'd2, 16'h0010));
        set_origin(8'd21);
        emit(rtype(5'd0, 5'd0, 5'd0, 6'h08));
        emit(rtype(5'd2, 5'd5, 5'd2, 6'h21));
    endtask

    task automatic store_program();
        emit(itype(6'h09, 5'd0, 5'd1, 16'h1000));
        emit(itype(6'h09, 5'd0, 5'd6, 16'hfff9));
        emit(itype(6'h2b, 5'd1, 5'd6, 16'h0008));
        emit(itype(6'h2b, 5'd1, 5'd1, 16'h000c));
        emit(itype(6'h23, 5'd1, 5'd2, 16'h0008));
        emit(itype(6'h23, 5'd1, 5'd7, 16'h000c));
        emit(jump_to(8'd9));
        emit(rtype(5'd2, 5'd7, 5'd2, 6'h21));
        set_origin(8'd9);
        emit(itype(6'h23, 5'd1, 5'd2, 16'h0010));
        emit(itype(6'h2b, 5'd1, 5'd2, 16'h0014));
        // the store in the delay slot still happens
        emit(rtype(5'd0, 5'd0, 5'd0, 6'h08));
        emit(itype(6'h2b, 5'd1, 5'd7, 16'h0018));
    endtask

    task automatic random_program();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        for (int i = 0; i < 40; i++) begin
            r  = $random(seed);
            rs = {2'b00, r[2:0]};
            rt = {2'b00, r[5:3]};
            rd = {2'b00, r[8:6]};
            case (r[11:9])
                3'd1, 3'd7: emit(rtype(rs, rt, rd, 6'h21));
                3'd2: emit(rtype(rs, rt, rd, 6'h23));
                3'd3: emit(rtype(rs, rt, rd, 6'h24));
                3'd4: emit(rtype(rs, rt, rd, 6'h25));
                3'd5: emit(rtype(rs, rt, rd, 6'h2a));
                default: emit(itype(6'h09, rs, rd, r[31:16]));
            endcase
        end
        emit(rtype(5'd0, 5'd0, 5'd0, 6'h08));
        emit(32'h0);
    endtask

    task automatic run_program(string name);
        int cycles;
        int limit;
        if (timeouts != 0) begin
            return;
        end
        limit  = 16 + prog_len + 64;
        cycles = 0;
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (16) begin
            @(posedge clk);
            cycles++;
        end
        #1 reset = 1'b0;
        model        = '0;
        model.pc     = reset_vector;
        model.active = 1'b1;
        checking     = 1'b1;
        while (active && cycles < limit) begin
            @(posedge clk);
            #1 cycles++;
        end
        if (active) begin
            $display("timeout: processor did not halt in the %s program", name);
            timeouts++;
            error_count++;
        end
        // a few idle cycles to see that nothing moves after the halt
        repeat (4) @(posedge clk);
        #1 checking = 1'b0;
    endtask

    // outputs are compared mid-cycle, then the model takes the same step
    always @(negedge clk) begin
        logic [31:0] instr;
        logic [31:0] addr;
        logic        store;
        logic        load;
        if (reset) begin
            check_bit("data_write", 1'b0, data_write);
            check_bit("data_read", 1'b0, data_read);
        end else if (checking) begin
            check_bit("active", model.active, active);
            check_word("register_v0", model.regs[reg_v0], register_v0);
            // pc holds once halted
            check_word("instr_address", model.pc, instr_address);
            store = 1'b0;
            load  = 1'b0;
            if (model.active) begin
                instr = fetch_word(model.pc);
                addr  = model.regs[instr[25:21]] + {{16{instr[15]}}, instr[15:0]};
                store = (instr[31:26] == 6'h2b);
                load  = (instr[31:26] == 6'h23);
                if (store || load) begin
                    check_word("data_address", addr, data_address);
                end
                if (store) begin
                    check_word("data_writedata", model.regs[instr[20:16]], data_writedata);
                    if (addr[31:10] == data_base[31:10]) begin
                        model_data[addr[9:2]] = model.regs[instr[20:16]];
                    end
                end
                model = model_step(model, instr);
            end
            check_bit("data_write", store, data_write);
            check_bit("data_read", load, data_read);
        end
    end

    initial begin
        reset       = 1'b1;
        checking    = 1'b0;
        error_count = 0;
        timeouts    = 0;
        seed        = 65223;
        model       = '0;
        clear_memories();
        boot_program();
        run_program("boot");
        clear_memories();
        branch_program();
        run_program("branch");
        clear_memories();
        store_program();
        run_program("store");
        clear_memories();
        random_program();
        run_program("random");
        $display("errors: %0d, timeouts: %0d", error_count, timeouts);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* compile.f */
design/mips_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/branch_unit.sv
design/pc_sequencer.sv
design/mips_cpu.sv
test/test_memory.sv
test/mips_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the mips_cpu testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps -f compile.f --top-module mips_cpu_tb -o mips_cpu_sim
sim_output=$(./obj_dir/mips_cpu_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "Finished with no errors"
